// File: all.f
design/audio_udp_pkg.sv
design/eth_crc32.sv
design/audio_gate.sv
design/audio_packer.sv
design/udp_frame_tx.sv
design/audio_udp_top.sv
tests/audio_udp_props.sv
tests/audio_udp_tb.sv

// File: run.sh
#!/bin/sh
# build and run the audio udp testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module audio_udp_tb \
   -f all.f -o audio_udp_sim || exit 1
# a run that stops on its own, such as on an assertion error, counts as failed
./obj_dir/audio_udp_sim > sim.log 2>&1 || echo "TESTBENCH FAILED" >> sim.log
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && exit 1
exit 0

// File: tests/audio_udp_tb.sv
// audio udp streamer testbench
`timescale 1ns/1ps

module audio_udp_tb import audio_udp_pkg::*; ();

   // ******************************
   // dut setup
   localparam logic [47:0] BOARD_MAC   = 48'h02_1a_2b_3c_4d_5e;
   localparam logic [47:0] DES_MAC     = 48'h06_a0_b0_c0_d0_e0;
   localparam logic [31:0] BOARD_IP    = {8'd10, 8'd0, 8'd0, 8'd2};
   localparam logic [31:0] DES_IP      = {8'd10, 8'd0, 8'd0, 8'd1};
   localparam logic [15:0] SRC_PORT    = 16'd5004;
   localparam logic [15:0] DES_PORT    = 16'd5006;
   localparam int          PKT_SAMPLES = 16;
   localparam int          IDLE_LIMIT  = 40;

   // wire layout of one frame
   localparam int          PAY_OFS     = 8 + 14 + 20 + 8;   // preamble and headers
   localparam int          FCS_OFS     = PAY_OFS + 2 * PKT_SAMPLES;
   localparam int          FRAME_BYTES = FCS_OFS + 4;       // 86 bytes
   localparam logic [15:0] UDP_LEN     = 16'(8 + 2 * PKT_SAMPLES);
   localparam logic [15:0] IP_LEN      = 16'(20 + 8 + 2 * PKT_SAMPLES);
   localparam int          TIMEOUT     = 3000;              // cycles per wait loop
   localparam int          QUIET       = 150;               // > IDLE_LIMIT plus one frame start

   logic        audio_clk;
   logic        rst_n;
   logic        audio_en;
   sample_t     audio_data;
   logic        key;
   logic        gmii_tx_en;
   logic [7:0]  gmii_txd;
   logic        led;
   logic [15:0] drop_count;

   logic [7:0]  rx_q [$];    // bytes of the frame in flight
   sample_t     exp_q [$];   // accepted samples, in send order
   sample_t     drv_q [$];   // every sample driven
   integer      seed = 32'h6f5856d0;
   int          err_count = 0;
   int          frame_count = 0;
   int          scan_pos = 0;      // overrun search start in drv_q
   bit          run_mode = 1'b0;   // 0 exact order, 1 consecutive run search

   audio_udp_top #(
      .BOARD_MAC(BOARD_MAC), .BOARD_IP(BOARD_IP), .DES_MAC(DES_MAC), .DES_IP(DES_IP),
      .SRC_PORT(SRC_PORT), .DES_PORT(DES_PORT), .PKT_SAMPLES(PKT_SAMPLES),
      .IDLE_LIMIT(IDLE_LIMIT)
   ) UUT (
      .audio_clk(audio_clk), .rst_n(rst_n), .audio_en(audio_en), .audio_data(audio_data),
      .key(key), .gmii_tx_en(gmii_tx_en), .gmii_txd(gmii_txd), .led(led),
      .drop_count(drop_count)
   );

   initial begin
      audio_clk = 1'b0;
      forever #4 audio_clk = ~audio_clk;   // 125 MHz byte clock
   end

   // ******************************
   // compare tasks
   task automatic flag_check(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("mismatch at %0t: %s got %0b expected %0b", $time, name, got, exp);
         err_count++;
      end
   endtask

   task automatic byte_check(input string name, input logic [7:0] got, input logic [7:0] exp);
      if (got !== exp) begin
         $display("mismatch at %0t: %s got %02h expected %02h", $time, name, got, exp);
         err_count++;
      end
   endtask

   task automatic sample_check(input string name, input sample_t got, input sample_t exp);
      if (got !== exp) begin
         $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
         err_count++;
      end
   endtask

   task automatic count_check(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
      if (got !== exp) begin
         $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
         err_count++;
      end
   endtask

   // ******************************
   // reference models
   function automatic logic [15:0] ones_csum(input logic [159:0] hdr);
      logic [31:0] sum;
      sum = '0;
      for (int i = 0; i < 10; i++) begin
         sum = sum + 32'(hdr[16*i +: 16]);
      end
      while (sum[31:16] != 16'h0) begin
         sum = 32'(sum[15:0]) + 32'(sum[31:16]);   // end around carry
      end
      return ~sum[15:0];
   endfunction

   // reflected crc-32 over headers and payload
   function automatic logic [31:0] fcs_of_frame();
      logic [31:0] c;
      c = '1;
      for (int i = 8; i < FCS_OFS; i++) begin
         c = c ^ {24'h0, rx_q[i]};
         for (int b = 0; b < 8; b++) begin
            c = c[0] ? ((c >> 1) ^ 32'hedb8_8320) : (c >> 1);
         end
      end
      return ~c;
   endfunction

   // index of a run of driven samples equal to got, or -1
   function automatic int find_run(input sample_t got [PKT_SAMPLES], input int from);
      bit hit;
      for (int j = from; j + PKT_SAMPLES <= drv_q.size(); j++) begin
         hit = 1'b1;
         for (int k = 0; k < PKT_SAMPLES; k++) begin
            if (drv_q[j+k] !== got[k]) hit = 1'b0;
         end
         if (hit) return j;
      end
      return -1;
   endfunction

   // ******************************
   // frame monitor
   task automatic check_frame();
      logic [159:0] ip_hdr;
      logic [335:0] exp_hdr;
      logic [31:0]  fcs;
      sample_t      got [PKT_SAMPLES];
      int           pos;
      count_check("frame length", 16'(rx_q.size()), 16'(FRAME_BYTES));
      if (rx_q.size() != FRAME_BYTES) begin
         frame_count++;
         return;
      end
      for (int i = 0; i < 8; i++) begin
         byte_check($sformatf("preamble byte %0d", i), rx_q[i], (i == 7) ? 8'hd5 : 8'h55);
      end
      // ip id counts frames since reset
      ip_hdr = {8'h45, 8'h00, IP_LEN, 16'(frame_count), 16'h0000, 8'd64, 8'd17, 16'h0000,
                BOARD_IP, DES_IP};
      ip_hdr[79:64] = ones_csum(ip_hdr);
      exp_hdr = {DES_MAC, BOARD_MAC, 16'h0800, ip_hdr, SRC_PORT, DES_PORT, UDP_LEN, 16'h0};
      for (int i = 0; i < 42; i++) begin
         byte_check($sformatf("header byte %0d", i), rx_q[8+i], exp_hdr[8*(41-i) +: 8]);
      end
      for (int k = 0; k < PKT_SAMPLES; k++) begin
         got[k] = {rx_q[PAY_OFS+2*k], rx_q[PAY_OFS+2*k+1]};   // upper byte first
      end
      if (!run_mode) begin
         foreach (got[k]) begin
            if (exp_q.size() == 0) begin
               $display("frame %0d carries a sample that was never accepted", frame_count);
               err_count++;
            end else begin
               sample_check($sformatf("payload sample %0d", k), got[k], exp_q.pop_front());
            end
         end
      end else begin
         pos = find_run(got, scan_pos);
         if (pos < 0) begin
            $display("frame %0d payload is not a run of driven samples", frame_count);
            err_count++;
         end else begin
            scan_pos = pos + PKT_SAMPLES;
         end
      end
      fcs = fcs_of_frame();
      for (int i = 0; i < 4; i++) begin
         byte_check($sformatf("fcs byte %0d", i), rx_q[FCS_OFS+i], fcs[8*i +: 8]);
      end
      frame_count++;
   endtask

   always @(posedge audio_clk) begin
      if (gmii_tx_en) begin
         flag_check("led", led, 1'b0);   // lit while a frame is out
         rx_q.push_back(gmii_txd);
      end else if (rx_q.size() > 0) begin
         check_frame();   // frame just ended
         rx_q.delete();
      end
   end

   // ******************************
   // stimulus and waits
   task automatic drive_samples(input int n, input int gap, input bit keep);
      logic [31:0] rnd;
      sample_t     s;
      for (int i = 0; i < n; i++) begin
         @(negedge audio_clk);
         rnd = $random(seed);
         s = rnd[15:0];
         audio_en   = 1'b1;
         audio_data = s;
         drv_q.push_back(s);
         if (keep) exp_q.push_back(s);
         if (gap > 1) begin
            @(negedge audio_clk);
            audio_en = 1'b0;
            repeat (gap - 2) @(negedge audio_clk);
         end
      end
      @(negedge audio_clk);
      audio_en = 1'b0;
   endtask

   task automatic wait_frames(input int target);
      int cyc;
      cyc = 0;
      while (frame_count < target && cyc < TIMEOUT) begin
         @(negedge audio_clk);
         cyc++;
      end
      if (frame_count < target) begin
         $display("timeout at %0t: %0d of %0d frames seen", $time, frame_count, target);
         err_count++;
      end
   endtask

   // transmitter idle long enough for the stream to stop
   task automatic wait_idle();
      int cyc;
      int quiet;
      cyc   = 0;
      quiet = 0;
      while (quiet < QUIET && cyc < TIMEOUT) begin
         @(negedge audio_clk);
         cyc++;
         quiet = led ? quiet + 1 : 0;
      end
      if (quiet < QUIET) begin
         $display("timeout at %0t: transmitter never went idle", $time);
         err_count++;
      end
   endtask

   task automatic report_test(input string name, input int errs_before);
      if (err_count == errs_before) $display("test %s: ok", name);
      else $display("test %s: failed with %0d errors", name, err_count - errs_before);
   endtask

   // ******************************
   // directed tests
   task automatic steady_stream();
      int e0;
      int f0;
      e0 = err_count;
      f0 = frame_count;
      key = 1'b1;
      drive_samples(3 * PKT_SAMPLES, 8, 1'b1);   // three packets, strobe every 8
      wait_frames(f0 + 3);
      wait_idle();
      count_check("frames sent", 16'(frame_count - f0), 16'd3);
      count_check("samples left unsent", 16'(exp_q.size()), 16'd0);
      count_check("drop_count", drop_count, 16'd0);
      report_test("steady_stream", e0);
   endtask

   task automatic key_press();
      int e0;
      int f0;
      e0 = err_count;
      f0 = frame_count;
      key = 1'b0;
      drive_samples(2 * PKT_SAMPLES, 8, 1'b0);   // long enough for a stray frame to end
      count_check("frames with key low", 16'(frame_count - f0), 16'd0);
      key = 1'b1;   // well clear of the last delayed strobe
      drive_samples(2 * PKT_SAMPLES, 8, 1'b1);
      wait_frames(f0 + 2);
      wait_idle();
      count_check("frames sent", 16'(frame_count - f0), 16'd2);
      count_check("samples left unsent", 16'(exp_q.size()), 16'd0);
      report_test("key_press", e0);
   endtask

   task automatic idle_restart();
      int e0;
      int f0;
      e0 = err_count;
      f0 = frame_count;
      drive_samples(10, 8, 1'b0);   // partial packet, lost at the idle stop
      repeat (IDLE_LIMIT + 20) @(negedge audio_clk);
      count_check("frames after idle stop", 16'(frame_count - f0), 16'd0);
      drive_samples(PKT_SAMPLES, 8, 1'b1);
      wait_frames(f0 + 1);
      wait_idle();
      count_check("frames sent", 16'(frame_count - f0), 16'd1);
      count_check("samples left unsent", 16'(exp_q.size()), 16'd0);
      count_check("drop_count", drop_count, 16'd0);
      report_test("idle_restart", e0);
   endtask

   task automatic overrun();
      int e0;
      int f0;
      int d0;
      int frames;
      int drops;
      int leftover;
      e0       = err_count;
      f0       = frame_count;
      d0       = int'(drop_count);
      scan_pos = drv_q.size();
      run_mode = 1'b1;
      drive_samples(160, 1, 1'b0);   // strobe on every cycle
      wait_idle();
      run_mode = 1'b0;
      frames   = frame_count - f0;
      drops    = int'(drop_count) - d0;
      leftover = 160 - PKT_SAMPLES * frames - drops;
      if (frames < 2) begin
         $display("overrun sent only %0d frames", frames);
         err_count++;
      end
      if (drops == 0) begin
         $display("overrun dropped no samples");
         err_count++;
      end
      if (leftover < 0 || leftover >= PKT_SAMPLES) begin
         $display("sample accounting broken: %0d frames, %0d drops", frames, drops);
         err_count++;
      end
      report_test("overrun", e0);
   endtask

   // ******************************
   initial begin
      rst_n      = 1'b0;
      audio_en   = 1'b0;
      audio_data = '0;
      key        = 1'b0;
      repeat (2) @(negedge audio_clk);
      rst_n = 1'b1;
      flag_check("led after reset", led, 1'b1);
      flag_check("gmii_tx_en after reset", gmii_tx_en, 1'b0);
      count_check("drop_count after reset", drop_count, 16'd0);
      steady_stream();
      key_press();
      idle_restart();
      overrun();
      $display("tests 4, frames %0d, errors %0d", frame_count, err_count);
      if (err_count == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

// File: tests/audio_udp_props.sv
// frame transmitter checks
`timescale 1ns/1ps

module audio_udp_props #(
   parameter int PKT_SAMPLES = 16
) (
   input logic audio_clk,
   input logic rst_n,
   input logic tx_start,
   input logic tx_req,
   input logic tx_done,
   input logic gmii_tx_en
);

   localparam int FRAME_LEN = 8 + 14 + 20 + 8 + 2 * PKT_SAMPLES + 4;
   localparam int PAY_OFS   = 8 + 14 + 20 + 8;           // first payload byte of the frame
   localparam int PAY_END   = PAY_OFS + 2 * PKT_SAMPLES;

   logic [15:0] run_len;   // cycles in a row with tx_en high
   logic [4:0]  low_len;   // cycles in a row with tx_en low, saturates

   always_ff @(posedge audio_clk or negedge rst_n) begin
      if (!rst_n) begin
         run_len <= '0;
         low_len <= 5'd31;   // no frame before reset ends
      end else if (gmii_tx_en) begin
         run_len <= run_len + 1'b1;
         low_len <= '0;
      end else begin
         run_len <= '0;
         if (low_len != 5'd31) low_len <= low_len + 1'b1;
      end
   end

   // ******************************
   start_to_frame: assert property (@(posedge audio_clk) disable iff (!rst_n)
      tx_start && !gmii_tx_en |=> gmii_tx_en)
      else $error("no preamble on the cycle after tx_start");

   frame_length: assert property (@(posedge audio_clk) disable iff (!rst_n)
      $fell(gmii_tx_en) |-> run_len == 16'(FRAME_LEN))
      else $error("tx_en high for %0d cycles", $sampled(run_len));

   // run_len is the byte index inside the frame
   req_in_payload: assert property (@(posedge audio_clk) disable iff (!rst_n)
      tx_req |-> gmii_tx_en && run_len >= 16'(PAY_OFS) && run_len < 16'(PAY_END))
      else $error("tx_req outside the payload");

   // tx_done on the twelfth gap byte
   done_after_gap: assert property (@(posedge audio_clk) disable iff (!rst_n)
      tx_done |-> !gmii_tx_en && low_len >= 5'd11)
      else $error("tx_done before the gap ended");

   gap_before_frame: assert property (@(posedge audio_clk) disable iff (!rst_n)
      $rose(gmii_tx_en) |-> low_len >= 5'd12)
      else $error("interframe gap of %0d cycles", $sampled(low_len));

endmodule

bind udp_frame_tx audio_udp_props #(.PKT_SAMPLES(PKT_SAMPLES)) u_props (
   .audio_clk(audio_clk), .rst_n(rst_n), .tx_start(tx_start), .tx_req(tx_req),
   .tx_done(tx_done), .gmii_tx_en(gmii_tx_en)
);

// File: design/audio_udp_top.sv
// audio to udp streamer
`timescale 1ns/1ps

module audio_udp_top import audio_udp_pkg::*; #(
   parameter logic [MAC_W-1:0]  BOARD_MAC   = 48'ha0_b1_c2_d3_e1_e1,
   parameter logic [IPV4_W-1:0] BOARD_IP    = {8'd192, 8'd168, 8'd1, 8'd11},
   parameter logic [MAC_W-1:0]  DES_MAC     = 48'h84_a9_38_bf_c9_a0,
   parameter logic [IPV4_W-1:0] DES_IP      = {8'd192, 8'd168, 8'd1, 8'd10},
   parameter logic [PORT_W-1:0] SRC_PORT    = 16'd1234,
   parameter logic [PORT_W-1:0] DES_PORT    = 16'd1234,
   parameter int                PKT_SAMPLES = 16,    // even, payload of 18 bytes or more
   parameter int                IDLE_LIMIT  = 300
) (
   input  logic        audio_clk,   // also the byte clock
   input  logic        rst_n,
   input  logic        audio_en,
   input  sample_t     audio_data,
   input  logic        key,
   output logic        gmii_tx_en,
   output logic [7:0]  gmii_txd,
   output logic        led,         // low while a frame is out
   output logic [15:0] drop_count
);

   logic        sample_valid;
   sample_t     sample_data;
   logic        stream_on;
   logic        tx_start;
   logic        tx_req;
   word_t       tx_data;
   logic        tx_done;
   logic        crc_init;
   logic        crc_en;
   logic [7:0]  crc_byte;
   logic [31:0] crc_value;
   logic        busy;

   assign led = ~busy;

   // ******************************
   audio_gate #(.IDLE_LIMIT(IDLE_LIMIT)) u_gate (
      .audio_clk(audio_clk), .rst_n(rst_n), .audio_en(audio_en), .audio_data(audio_data),
      .key(key), .sample_valid(sample_valid), .sample_data(sample_data),
      .stream_on(stream_on)
   );

   audio_packer #(.PKT_SAMPLES(PKT_SAMPLES)) u_packer (
      .audio_clk(audio_clk), .rst_n(rst_n), .sample_valid(sample_valid),
      .sample_data(sample_data), .stream_on(stream_on), .tx_start(tx_start),
      .tx_req(tx_req), .tx_data(tx_data), .tx_done(tx_done), .drop_count(drop_count)
   );

   udp_frame_tx #(
      .BOARD_MAC(BOARD_MAC), .BOARD_IP(BOARD_IP), .DES_MAC(DES_MAC), .DES_IP(DES_IP),
      .SRC_PORT(SRC_PORT), .DES_PORT(DES_PORT), .PKT_SAMPLES(PKT_SAMPLES)
   ) u_frame_tx (
      .audio_clk(audio_clk), .rst_n(rst_n), .tx_start(tx_start), .tx_req(tx_req),
      .tx_data(tx_data), .tx_done(tx_done), .crc_init(crc_init), .crc_en(crc_en),
      .crc_byte(crc_byte), .crc_value(crc_value), .gmii_tx_en(gmii_tx_en),
      .gmii_txd(gmii_txd), .busy(busy)
   );

   eth_crc32 u_crc (
      .audio_clk(audio_clk), .rst_n(rst_n), .crc_init(crc_init), .crc_en(crc_en),
      .crc_byte(crc_byte), .crc_value(crc_value)
   );

endmodule

// File: design/udp_frame_tx.sv
// udp frame transmitter
`timescale 1ns/1ps

module udp_frame_tx import audio_udp_pkg::*; #(
   parameter logic [MAC_W-1:0]  BOARD_MAC   = 48'ha0_b1_c2_d3_e1_e1,
   parameter logic [IPV4_W-1:0] BOARD_IP    = {8'd192, 8'd168, 8'd1, 8'd11},
   parameter logic [MAC_W-1:0]  DES_MAC     = 48'h84_a9_38_bf_c9_a0,
   parameter logic [IPV4_W-1:0] DES_IP      = {8'd192, 8'd168, 8'd1, 8'd10},
   parameter logic [PORT_W-1:0] SRC_PORT    = 16'd1234,
   parameter logic [PORT_W-1:0] DES_PORT    = 16'd1234,
   parameter int                PKT_SAMPLES = 16
) (
   input  logic        audio_clk,
   input  logic        rst_n,
   input  logic        tx_start,
   output logic        tx_req,
   input  word_t       tx_data,
   output logic        tx_done,
   output logic        crc_init,
   output logic        crc_en,
   output logic [7:0]  crc_byte,
   input  logic [31:0] crc_value,
   output logic        gmii_tx_en,
   output logic [7:0]  gmii_txd,
   output logic        busy
);

   localparam int          PAY_BYTES = 2 * PKT_SAMPLES;
   localparam logic [15:0] UDP_LEN   = 16'(UDP_HDR_BYTES + PAY_BYTES);
   localparam logic [15:0] IP_LEN    = 16'(IP_HDR_BYTES + UDP_HDR_BYTES + PAY_BYTES);

   // sum of the header words that never change, id and checksum left out
   localparam logic [31:0] IP_SUM_FIXED = 32'h4500 + 32'(IP_LEN)
      + 32'({IP_TTL, IP_PROTO_UDP})
      + 32'(BOARD_IP[31:16]) + 32'(BOARD_IP[15:0])
      + 32'(DES_IP[31:16]) + 32'(DES_IP[15:0]);

   localparam logic [8*ETH_HDR_BYTES-1:0] ETH_HDR = {DES_MAC, BOARD_MAC, ETH_TYPE_IPV4};
   localparam logic [8*UDP_HDR_BYTES-1:0] UDP_HDR = {SRC_PORT, DES_PORT, UDP_LEN, 16'h0000};

   tx_state_t                 state;
   tx_state_t                 state_nxt;
   logic [15:0]               cnt;        // byte index inside the section
   logic [15:0]               cnt_last;
   logic [15:0]               frame_id;
   logic [15:0]               ip_csum;
   logic [8*IP_HDR_BYTES-1:0] ip_hdr;
   logic [7:0]                tx_byte;

   // ones complement sum with end around carry
   function automatic logic [15:0] ip_checksum(input logic [15:0] id);
      logic [31:0] sum;
      logic [16:0] fold;
      sum  = IP_SUM_FIXED + 32'(id);
      fold = 17'(sum[31:16]) + 17'(sum[15:0]);
      fold = 17'(fold[15:0]) + 17'(fold[16]);   // second carry
      return ~fold[15:0];
   endfunction

   // ******************************
   // section lengths and order
   always_comb begin
      cnt_last  = '0;
      state_nxt = TX_IDLE;
      case (state)
         TX_PREAMBLE: begin
            cnt_last  = 16'(PREAMBLE_BYTES - 1);
            state_nxt = TX_ETH_HDR;
         end
         TX_ETH_HDR: begin
            cnt_last  = 16'(ETH_HDR_BYTES - 1);
            state_nxt = TX_IP_HDR;
         end
         TX_IP_HDR: begin
            cnt_last  = 16'(IP_HDR_BYTES - 1);
            state_nxt = TX_UDP_HDR;
         end
         TX_UDP_HDR: begin
            cnt_last  = 16'(UDP_HDR_BYTES - 1);
            state_nxt = TX_PAYLOAD;
         end
         TX_PAYLOAD: begin
            cnt_last  = 16'(PAY_BYTES - 1);
            state_nxt = TX_FCS;
         end
         TX_FCS: begin
            cnt_last  = 16'(FCS_BYTES - 1);
            state_nxt = TX_GAP;
         end
         TX_GAP: begin
            cnt_last  = 16'(IFG_BYTES - 1);
            state_nxt = TX_IDLE;
         end
         default: ;
      endcase
   end

   always_ff @(posedge audio_clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= TX_IDLE;
         cnt      <= '0;
         frame_id <= '0;
         ip_csum  <= '0;
      end else if (state == TX_IDLE) begin
         cnt <= '0;
         if (tx_start) begin
            state   <= TX_PREAMBLE;            // first byte next cycle
            ip_csum <= ip_checksum(frame_id);
         end
      end else if (cnt == cnt_last) begin
         state <= state_nxt;
         cnt   <= '0;
         if (state == TX_GAP) begin
            frame_id <= frame_id + 1'b1;       // next ip id
         end
      end else begin
         cnt <= cnt + 1'b1;
      end
   end

   // ******************************
   // byte select
   assign ip_hdr = {8'h45, 8'h00, IP_LEN, frame_id, 16'h0000,   // v4 ihl 5, no df
                    IP_TTL, IP_PROTO_UDP, ip_csum, BOARD_IP, DES_IP};

   always_comb begin
      case (state)
         TX_PREAMBLE: tx_byte = (cnt == 16'(PREAMBLE_BYTES - 1)) ? 8'hd5 : 8'h55;
         TX_ETH_HDR:  tx_byte = ETH_HDR[8*(ETH_HDR_BYTES - 1 - int'(cnt)) +: 8];
         TX_IP_HDR:   tx_byte = ip_hdr[8*(IP_HDR_BYTES - 1 - int'(cnt)) +: 8];
         TX_UDP_HDR:  tx_byte = UDP_HDR[8*(UDP_HDR_BYTES - 1 - int'(cnt)) +: 8];
         TX_PAYLOAD:  tx_byte = tx_data[8*(3 - int'(cnt[1:0])) +: 8];   // upper byte first
         TX_FCS:      tx_byte = crc_value[8*int'(cnt[1:0]) +: 8];       // low byte first
         default:     tx_byte = 8'h00;
      endcase
   end

   assign gmii_txd   = tx_byte;
   assign gmii_tx_en = (state != TX_IDLE) && (state != TX_GAP);

   // crc covers headers and payload only
   assign crc_init = (state == TX_PREAMBLE) && (cnt == '0);
   assign crc_en   = (state inside {TX_ETH_HDR, TX_IP_HDR, TX_UDP_HDR, TX_PAYLOAD});
   assign crc_byte = tx_byte;

   // ask for the next word on the last byte of the current one
   assign tx_req  = (state == TX_PAYLOAD) && (cnt[1:0] == 2'd3)
                    && (cnt != 16'(PAY_BYTES - 1));
   assign tx_done = (state == TX_GAP) && (cnt == 16'(IFG_BYTES - 1));
   assign busy    = (state != TX_IDLE);

endmodule

// File: design/audio_packer.sv
// audio sample packer
`timescale 1ns/1ps

module audio_packer import audio_udp_pkg::*; #(
   parameter int PKT_SAMPLES = 16
) (
   input  logic        audio_clk,
   input  logic        rst_n,
   input  logic        sample_valid,
   input  sample_t     sample_data,
   input  logic        stream_on,
   output logic        tx_start,
   input  logic        tx_req,
   output word_t       tx_data,
   input  logic        tx_done,
   output logic [15:0] drop_count
);

   localparam int WORDS  = PKT_SAMPLES / 2;     // words per half
   localparam int IDX_W  = $clog2(WORDS);
   localparam int ADDR_W = $clog2(2 * WORDS);

   word_t             mem [2 * WORDS];          // half 0 low, half 1 high
   pkt_state_t        half_st [2];
   logic              wr_half;
   logic              rd_half;                  // half owned by the transmitter
   logic [IDX_W-1:0]  wr_idx;
   logic [IDX_W-1:0]  rd_idx;
   logic              pair_hi;                  // first sample of pair held
   sample_t           first_smp;
   logic              tx_active;                // frame between start and done
   logic              fill_ok;
   logic              drop;
   logic              word_wr;
   logic              half_done;
   logic              start_go;
   logic              start_half;
   logic [ADDR_W-1:0] wr_addr;
   logic [ADDR_W-1:0] rd_addr;

   function automatic logic [ADDR_W-1:0] word_addr(input logic half,
                                                   input logic [IDX_W-1:0] idx);
      return half ? ADDR_W'(WORDS) + ADDR_W'(idx) : ADDR_W'(idx);
   endfunction

   // ******************************
   // write side
   always_comb begin
      fill_ok   = sample_valid && stream_on && (half_st[wr_half] == PKT_FILLING);
      drop      = sample_valid && stream_on && (half_st[wr_half] != PKT_FILLING);
      word_wr   = fill_ok && pair_hi;                             // second of the pair
      half_done = word_wr && (wr_idx == IDX_W'(WORDS - 1));
   end

   // next frame, chained straight off tx_done when the other half waits
   always_comb begin
      start_go   = 1'b0;
      start_half = ~rd_half;
      if (tx_done) begin
         start_go = (half_st[~rd_half] == PKT_FULL);
      end else if (!tx_active) begin
         if (half_st[~rd_half] == PKT_FULL) begin
            start_go = 1'b1;
         end else if (half_st[rd_half] == PKT_FULL) begin
            start_go   = 1'b1;
            start_half = rd_half;
         end
      end
   end

   assign wr_addr = word_addr(wr_half, wr_idx);
   assign rd_addr = start_go ? word_addr(start_half, '0) : word_addr(rd_half, rd_idx);

   // ******************************
   // buffer and read port, word 0 prefetched at start
   always_ff @(posedge audio_clk) begin
      if (fill_ok && !pair_hi) begin
         first_smp <= sample_data;
      end
      if (word_wr) begin
         mem[wr_addr] <= {first_smp, sample_data};
      end
      if (start_go || tx_req) begin
         tx_data <= mem[rd_addr];   // valid the cycle after the request
      end
   end

   always_ff @(posedge audio_clk or negedge rst_n) begin
      if (!rst_n) begin
         half_st[0] <= PKT_FILLING;
         half_st[1] <= PKT_FILLING;
         wr_half    <= 1'b0;
         rd_half    <= 1'b0;
         wr_idx     <= '0;
         rd_idx     <= '0;
         pair_hi    <= 1'b0;
         tx_active  <= 1'b0;
         tx_start   <= 1'b0;
         drop_count <= '0;
      end else begin
         tx_start <= start_go;
         if (!stream_on) begin
            wr_idx  <= '0;   // partial packet thrown away
            pair_hi <= 1'b0;
         end else if (fill_ok) begin
            pair_hi <= ~pair_hi;
            if (half_done) begin
               wr_idx  <= '0;
               wr_half <= ~wr_half;
            end else if (pair_hi) begin
               wr_idx <= wr_idx + 1'b1;
            end
         end
         if (drop) begin
            drop_count <= drop_count + 1'b1;   // both halves busy
         end
         // half ownership
         if (tx_done) begin
            half_st[rd_half] <= PKT_FILLING;
         end
         if (half_done) begin
            half_st[wr_half] <= PKT_FULL;
         end
         if (start_go) begin
            half_st[start_half] <= PKT_SENDING;
            rd_half   <= start_half;
            rd_idx    <= IDX_W'(1);           // word 0 already loaded
            tx_active <= 1'b1;
         end else begin
            if (tx_done) begin
               tx_active <= 1'b0;
            end
            if (tx_req) begin
               rd_idx <= rd_idx + 1'b1;
            end
         end
      end
   end

endmodule

// File: design/audio_gate.sv
// audio capture gate
`timescale 1ns/1ps

module audio_gate import audio_udp_pkg::*; #(
   parameter int IDLE_LIMIT = 300
) (
   input  logic    audio_clk,
   input  logic    rst_n,
   input  logic    audio_en,      // sample strobe
   input  sample_t audio_data,
   input  logic    key,           // stream request, held high
   output logic    sample_valid,
   output sample_t sample_data,
   output logic    stream_on
);

   localparam int IDLE_W = $clog2(IDLE_LIMIT + 1);

   logic [1:0]        en_dly;     // strobe shift pipe
   sample_t           data_dly [2];
   logic [IDLE_W-1:0] idle_cnt;
   logic              idle_sat;

   // ******************************
   // two cycle delay of strobe and data
   always_ff @(posedge audio_clk or negedge rst_n) begin
      if (!rst_n) begin
         en_dly <= '0;
      end else begin
         en_dly <= {en_dly[0], audio_en};
      end
   end

   always_ff @(posedge audio_clk) begin
      data_dly[0] <= audio_data;
      data_dly[1] <= data_dly[0];   // lines up with en_dly[1]
   end

   assign sample_valid = en_dly[1];
   assign sample_data  = data_dly[1];

   // ******************************
   // idle timer, counts cycles since the last strobe
   assign idle_sat = (idle_cnt == IDLE_W'(IDLE_LIMIT));

   always_ff @(posedge audio_clk or negedge rst_n) begin
      if (!rst_n) begin
         idle_cnt <= IDLE_W'(IDLE_LIMIT);   // idle until the first strobe
      end else if (audio_en) begin
         idle_cnt <= '0;
      end else if (!idle_sat) begin
         idle_cnt <= idle_cnt + 1'b1;       // holds once saturated
      end
   end

   // key held and strobes still coming
   assign stream_on = key && !idle_sat;

endmodule

// File: design/eth_crc32.sv
// ethernet fcs generator
`timescale 1ns/1ps

module eth_crc32 (
   input  logic        audio_clk,
   input  logic        rst_n,
   input  logic        crc_init,
   input  logic        crc_en,
   input  logic [7:0]  crc_byte,
   output logic [31:0] crc_value
);

   localparam logic [31:0] CRC_POLY = 32'h04c1_1db7;

   logic [31:0] crc_q;

   // one byte, eight shifts of the msb first register
   function automatic logic [31:0] crc_step(input logic [31:0] crc, input logic [7:0] data);
      logic [31:0] c;
      logic        fb;
      c = crc;
      for (int i = 0; i < 8; i++) begin
         fb = c[31] ^ data[i];   // bit 0 goes out on the wire first
         c  = {c[30:0], 1'b0};
         if (fb) begin
            c = c ^ CRC_POLY;
         end
      end
      return c;
   endfunction

   always_ff @(posedge audio_clk or negedge rst_n) begin
      if (!rst_n) begin
         crc_q <= '1;
      end else if (crc_init) begin
         crc_q <= '1;                     // preset all ones
      end else if (crc_en) begin
         crc_q <= crc_step(crc_q, crc_byte);
      end
   end

   // complement and reverse, byte 0 of the fcs in [7:0]
   always_comb begin
      for (int i = 0; i < 32; i++) begin
         crc_value[i] = ~crc_q[31-i];
      end
   end

endmodule

// File: design/audio_udp_pkg.sv
// audio udp shared definitions
package audio_udp_pkg;

   // ******************************
   // field widths for address parameters
   localparam int MAC_W  = 48;
   localparam int IPV4_W = 32;
   localparam int PORT_W = 16;

   // ******************************
   // frame layout in bytes
   localparam int PREAMBLE_BYTES = 8;    // seven 0x55 then sfd
   localparam int ETH_HDR_BYTES  = 14;   // dst mac, src mac, ethertype
   localparam int IP_HDR_BYTES   = 20;   // no options
   localparam int UDP_HDR_BYTES  = 8;
   localparam int FCS_BYTES      = 4;
   localparam int IFG_BYTES      = 12;   // minimum interframe gap

   // fixed header values
   localparam logic [15:0] ETH_TYPE_IPV4 = 16'h0800;
   localparam logic [7:0]  IP_TTL        = 8'd64;
   localparam logic [7:0]  IP_PROTO_UDP  = 8'd17;

   typedef logic signed [15:0] sample_t;   // one audio sample
   typedef logic [31:0] word_t;            // first sample in [31:16], sent upper byte first

   // transmitter sequence, one state per frame section
   typedef enum logic [2:0] {
      TX_IDLE, TX_PREAMBLE, TX_ETH_HDR, TX_IP_HDR,
      TX_UDP_HDR, TX_PAYLOAD, TX_FCS, TX_GAP
   } tx_state_t;

   // per buffer half
   typedef enum logic [1:0] {
      PKT_FILLING,   // free or taking samples
      PKT_FULL,      // waiting for the transmitter
      PKT_SENDING    // being read out
   } pkt_state_t;

endpackage
